// ==== hdl/bubl_pkg.sv ====
/*
 * Shared definitions for the main CPU bus controller
 *   bus and ROM widths
 *   ROM bank arithmetic constants
 *   fixed read values for open bus, Tokio MCU RAM and cabinet padding
 *   misc control byte with its Bubble Bobble and Tokio views
 */

package bubl_pkg;

    ////////////////////////////////////////////////////
    // Bus widths
    localparam int addr_w      = 16;
    localparam int data_w      = 8;
    localparam int rom_addr_w  = 18;
    localparam int cpu_addr_w  = 13;   // Address seen by the video side

    ////////////////////////////////////////////////////
    // ROM banking
    localparam int bank_w        = 3;
    localparam int bank_win_bits = 14;  // 16 kB window at 8000
    localparam int bank_page_w   = rom_addr_w - bank_win_bits;

    localparam logic [bank_page_w-1:0] bank_base = 4'd2;  // Pages start at 32 kB
    localparam logic [bank_w-1:0]      bank_xor  = 3'd4;

    ////////////////////////////////////////////////////
    // Fixed read values
    localparam logic [data_w-1:0] open_bus        = 8'hff;
    localparam logic [data_w-1:0] tokio_mcram_val = 8'hbf;
    localparam logic [1:0]        pad_unused      = 2'b11;

    // Misc control byte, laid out differently by each game
    typedef union packed {
        struct packed {
            logic              flip;
            logic              blank_n;
            logic              mcu_run;
            logic              sub_run;
            logic              spare;
            logic [bank_w-1:0] bank;
        } misc_bubl;
        struct packed {
            logic              flip;
            logic              blank_n;
            logic [2:0]        spare;    // Unused by Tokio
            logic [bank_w-1:0] bank;
        } misc_tokio;
    } misc_ctrl_u;

endpackage

// ==== hdl/main_addr_dec.sv ====
/*
 * Main CPU memory map decoder
 *   common ROM, VRAM, work RAM and palette regions
 *   Bubble Bobble and Tokio register areas
 *   chip selects and write strobes, all combinational
 */

`timescale 1ns/100ps

module main_addr_dec(
    input                         tokio,
    input  [bubl_pkg::addr_w-1:0] main_addr,
    input                         main_mreq_n,
    input                         main_wr_n,
    output logic                  main_rom_cs,
    output logic                  vram_cs,
    output logic                  pal_cs,
    output logic                  work_sel,
    output logic                  mcram_sel,
    output logic                  misc_we,
    output logic                  flip_we,
    output logic                  snd_sel,
    output logic                  cab_sel,
    output logic                  sub_nmi
);
    import bubl_pkg::*;

    logic [7:0] page;   // Upper address byte
    logic       wr;

    assign page = main_addr[addr_w-1 -: 8];
    assign wr   = !main_wr_n;

    always_comb begin
        {main_rom_cs, vram_cs, pal_cs, work_sel, mcram_sel} = '0;
        {misc_we, flip_we, snd_sel, cab_sel, sub_nmi}       = '0;
        if (!main_mreq_n) begin
            main_rom_cs = page < 8'hc0;                      // 0000-BFFF
            vram_cs     = page[7:5] == 3'b110;               // C000-DFFF
            work_sel    = page[7:5] == 3'b111 && page[4:3] != 2'b11;
            pal_cs      = page[7:1] == 7'b1111_100;          // F800-F9FF
            if (tokio) begin
                cab_sel   = page == 8'hfa && !main_addr[7] && !wr;
                misc_we   = page == 8'hfa &&  main_addr[7] && wr;
                flip_we   = page == 8'hfb && !main_addr[7] && wr;
                sub_nmi   = page == 8'hfb &&  main_addr[7] && wr;
                snd_sel   = page == 8'hfc && !main_addr[7];
                mcram_sel = page[7:1] == 7'b1111_111;        // FE00-FFFF
            end else begin
                // Bubble Bobble, flip lives in the misc byte
                snd_sel   = page == 8'hfa && !main_addr[7];
                sub_nmi   = page == 8'hfb && main_addr[7:6] == 2'b00 && wr;
                misc_we   = page == 8'hfb && main_addr[7:6] == 2'b01 && wr;
                mcram_sel = page[7:2] == 6'b1111_11;         // FC00-FFFF
            end
        end
    end

endmodule

// ==== hdl/main_ctrl_reg.sv ====
/*
 * Misc control register
 *   bank, blanking, flip, sub CPU and MCU reset bits
 *   per-game decoding of the written byte
 *   banked main ROM address
 */

`timescale 1ns/100ps

module main_ctrl_reg(
    input                             clk24,
    input                             rst,
    input                             tokio,
    input                             misc_we,
    input                             flip_we,
    input  [bubl_pkg::data_w-1:0]     main_dout,
    input  [bubl_pkg::addr_w-1:0]     main_addr,
    output [bubl_pkg::rom_addr_w-1:0] main_rom_addr,
    output logic                      black_n,
    output logic                      flip,
    output logic                      sub_rst_n,
    output logic                      mcu_rst
);
    import bubl_pkg::*;

    misc_ctrl_u       ctrl;     // Byte on the bus, two views
    logic [bank_w-1:0] bank;

    assign ctrl = main_dout;

    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            bank      <= '0;
            black_n   <= 1'b0;
            flip      <= 1'b0;
            sub_rst_n <= 1'b0;
            mcu_rst   <= 1'b1;
        end else begin
            if (misc_we && tokio) begin
                bank      <= ctrl.misc_tokio.bank ^ bank_xor;
                black_n   <= ctrl.misc_tokio.blank_n;
                sub_rst_n <= 1'b1;      // No sub CPU control
                mcu_rst   <= 1'b1;
            end else if (misc_we) begin
                bank      <= ctrl.misc_bubl.bank ^ bank_xor;
                black_n   <= ctrl.misc_bubl.blank_n;
                flip      <= ctrl.misc_bubl.flip;
                sub_rst_n <= ctrl.misc_bubl.sub_run;
                mcu_rst   <= ~ctrl.misc_bubl.mcu_run;
            end
            if (flip_we && tokio)
                flip <= ctrl.misc_tokio.flip;   // Separate flip address
        end
    end

    assign main_rom_addr = main_addr[addr_w-1] ?
        {{1'b0, bank} + bank_base, main_addr[bank_win_bits-1:0]} :  // Banked window
        {{(rom_addr_w-15){1'b0}}, main_addr[14:0]};

endmodule

// ==== hdl/snd_comm.sv ====
/*
 * Main to sound CPU communication
 *   command latch and its strobe
 *   sound CPU reset control
 *   handshake flag, cleared by a main read, set by main_stb
 */

`timescale 1ns/100ps

module snd_comm(
    input                               clk24,
    input                               rst,
    input                               snd_sel,
    input        [1:0]                  main_addr,
    input        [bubl_pkg::data_w-1:0] main_dout,
    input                               main_wr_n,
    input                               main_rd_n,
    input                               main_stb,
    output logic [bubl_pkg::data_w-1:0] snd_latch,
    output logic                        snd_stb,
    output logic                        snd_rstn,
    output logic                        main_flag
);
    logic snd_wr;
    logic stb_last;     // main_stb one cycle back

    assign snd_wr = snd_sel && !main_wr_n;

    ////////////////////////////////////////////////////
    // Latch, strobe and reset
    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            snd_latch <= '0;
            snd_stb   <= 1'b0;
            snd_rstn  <= 1'b1;  // Sound CPU runs from power up
        end else begin
            snd_stb <= snd_wr && main_addr == 2'd0;
            if (snd_wr && main_addr == 2'd0)
                snd_latch <= main_dout;
            if (snd_wr && main_addr == 2'd3)
                snd_rstn <= ~main_dout[0];
        end
    end

    ////////////////////////////////////////////////////
    // Handshake flag
    always_ff @(posedge clk24, posedge rst) begin
        if (rst) begin
            stb_last  <= 1'b0;
            main_flag <= 1'b1;
        end else begin
            stb_last <= main_stb;
            if (main_stb && !stb_last)
                main_flag <= 1'b1;                  // Rising edge wins
            else if (snd_sel && !main_rd_n)
                main_flag <= 1'b0;
        end
    end

endmodule

// ==== hdl/cab_port.sv ====
/*
 * Tokio cabinet and DIP input port
 *   one registered byte per address
 *   joystick bits reordered as on the board
 */

`timescale 1ns/100ps

module cab_port(
    input                               clk24,
    input                               rst,
    input        [2:0]                  main_addr,
    input        [bubl_pkg::data_w-1:0] dipsw_a,
    input        [bubl_pkg::data_w-1:0] dipsw_b,
    input        [1:0]                  coin_input,
    input        [1:0]                  start_button,
    input        [5:0]                  joystick1,
    input        [5:0]                  joystick2,
    output logic [bubl_pkg::data_w-1:0] cab_dout
);
    import bubl_pkg::*;

    function automatic logic [data_w-1:0] player_byte(input logic start, input logic [5:0] joy);
        player_byte = {1'b1, start, joy[4], joy[5], joy[3:2], joy[0], joy[1]};
    endfunction

    always_ff @(posedge clk24, posedge rst) begin
        if (rst)
            cab_dout <= open_bus;
        else begin
            case (main_addr)
                3'd3:    cab_dout <= dipsw_a;
                3'd4:    cab_dout <= dipsw_b;
                3'd5:    cab_dout <= {pad_unused, pad_unused, coin_input, pad_unused};
                3'd6:    cab_dout <= player_byte(start_button[0], joystick1);
                3'd7:    cab_dout <= player_byte(start_button[1], joystick2);
                default: cab_dout <= open_bus;
            endcase
        end
    end

endmodule

// ==== hdl/main_din_mux.sv ====
/*
 * Main CPU read data mux
 *   fixed priority over the selected sources
 *   sound status byte and fixed region values
 */

`timescale 1ns/100ps

module main_din_mux(
    input                               clk24,
    input                               rst,
    input                               tokio,
    input                               main_rom_cs,
    input                               vram_cs,
    input                               pal_cs,
    input                               work_sel,
    input                               mcram_sel,
    input                               snd_sel,
    input                               cab_sel,
    input                               main_addr0,
    input                               main_flag,
    input                               snd_flag,
    input        [bubl_pkg::data_w-1:0] main_rom_data,
    input        [bubl_pkg::data_w-1:0] vram_dout,
    input        [bubl_pkg::data_w-1:0] pal_dout,
    input        [bubl_pkg::data_w-1:0] main_latch,
    input        [bubl_pkg::data_w-1:0] cab_dout,
    output logic [bubl_pkg::data_w-1:0] main_din
);
    import bubl_pkg::*;

    always_ff @(posedge clk24, posedge rst) begin
        if (rst)
            main_din <= open_bus;
        else if (main_rom_cs) main_din <= main_rom_data;
        else if (vram_cs)     main_din <= vram_dout;
        else if (pal_cs)      main_din <= pal_dout;
        else if (work_sel)    main_din <= open_bus;     // No work RAM here
        else if (mcram_sel)   main_din <= tokio ? tokio_mcram_val : open_bus;
        else if (snd_sel)
            main_din <= main_addr0 ? {{(data_w-2){1'b1}}, main_flag, snd_flag} : main_latch;
        else if (cab_sel)     main_din <= cab_dout;
        else                  main_din <= open_bus;
    end

endmodule

// ==== hdl/bubl_main_bus.sv ====
/*
 * Main CPU bus controller, top level
 *   address decoder
 *   misc control register and ROM banking
 *   sound communication, Tokio cabinet port, read mux
 */

`timescale 1ns/100ps

module bubl_main_bus(
    input                               clk24,
    input                               rst,
    input                               tokio,
    // CPU bus
    input  [bubl_pkg::addr_w-1:0]       main_addr,
    input  [bubl_pkg::data_w-1:0]       main_dout,
    input                               main_mreq_n,
    input                               main_iorq_n,
    input                               main_rd_n,
    input                               main_wr_n,
    output [bubl_pkg::data_w-1:0]       main_din,
    // Memories and video
    input  [bubl_pkg::data_w-1:0]       main_rom_data,
    input  [bubl_pkg::data_w-1:0]       vram_dout,
    input  [bubl_pkg::data_w-1:0]       pal_dout,
    output [bubl_pkg::rom_addr_w-1:0]   main_rom_addr,
    output                              main_rom_cs,
    output                              vram_cs,
    output                              pal_cs,
    output [bubl_pkg::cpu_addr_w-1:0]   cpu_addr,
    output [bubl_pkg::data_w-1:0]       cpu_dout,
    output                              cpu_rnw,
    // Control
    output                              black_n,
    output                              flip,
    output                              sub_rst_n,
    output                              mcu_rst,
    output                              sub_nmi,
    // Sound
    input  [bubl_pkg::data_w-1:0]       main_latch,
    input                               snd_flag,
    input                               main_stb,
    output [bubl_pkg::data_w-1:0]       snd_latch,
    output                              snd_stb,
    output                              snd_rstn,
    output                              main_flag,
    // Cabinet
    input  [1:0]                        start_button,
    input  [1:0]                        coin_input,
    input  [5:0]                        joystick1,
    input  [5:0]                        joystick2,
    input  [bubl_pkg::data_w-1:0]       dipsw_a,
    input  [bubl_pkg::data_w-1:0]       dipsw_b
);
    import bubl_pkg::*;

    logic              misc_we, flip_we, snd_sel, cab_sel, mcram_sel, work_sel;
    logic              mem_req_n;
    logic [data_w-1:0] cab_dout;

    assign mem_req_n = main_mreq_n | ~main_iorq_n;  // I/O cycles never hit memory
    assign cpu_addr  = main_addr[cpu_addr_w-1:0];
    assign cpu_dout  = main_dout;
    assign cpu_rnw   = main_wr_n;

    main_addr_dec main_addr_dec_i(
        .tokio(tokio), .main_addr(main_addr), .main_mreq_n(mem_req_n),
        .main_wr_n(main_wr_n), .main_rom_cs(main_rom_cs), .vram_cs(vram_cs),
        .pal_cs(pal_cs), .work_sel(work_sel), .mcram_sel(mcram_sel), .misc_we(misc_we),
        .flip_we(flip_we), .snd_sel(snd_sel), .cab_sel(cab_sel), .sub_nmi(sub_nmi));

    main_ctrl_reg main_ctrl_reg_i(
        .clk24(clk24), .rst(rst), .tokio(tokio), .misc_we(misc_we), .flip_we(flip_we),
        .main_dout(main_dout), .main_addr(main_addr), .main_rom_addr(main_rom_addr),
        .black_n(black_n), .flip(flip), .sub_rst_n(sub_rst_n), .mcu_rst(mcu_rst));

    snd_comm snd_comm_i(
        .clk24(clk24), .rst(rst), .snd_sel(snd_sel), .main_addr(main_addr[1:0]),
        .main_dout(main_dout), .main_wr_n(main_wr_n), .main_rd_n(main_rd_n),
        .main_stb(main_stb), .snd_latch(snd_latch), .snd_stb(snd_stb),
        .snd_rstn(snd_rstn), .main_flag(main_flag));

    cab_port cab_port_i(
        .clk24(clk24), .rst(rst), .main_addr(main_addr[2:0]), .dipsw_a(dipsw_a),
        .dipsw_b(dipsw_b), .coin_input(coin_input), .start_button(start_button),
        .joystick1(joystick1), .joystick2(joystick2), .cab_dout(cab_dout));

    main_din_mux main_din_mux_i(
        .clk24(clk24), .rst(rst), .tokio(tokio), .main_rom_cs(main_rom_cs),
        .vram_cs(vram_cs), .pal_cs(pal_cs), .work_sel(work_sel), .mcram_sel(mcram_sel),
        .snd_sel(snd_sel), .cab_sel(cab_sel), .main_addr0(main_addr[0]),
        .main_flag(main_flag), .snd_flag(snd_flag), .main_rom_data(main_rom_data),
        .vram_dout(vram_dout), .pal_dout(pal_dout), .main_latch(main_latch),
        .cab_dout(cab_dout), .main_din(main_din));

endmodule

// ==== tests/bubl_main_bus_asserts.sv ====
/*
 * Decoder rules, bound into main_addr_dec
 *   one select at a time
 *   nothing selected without a memory request
 *   Tokio-only strobes
 */

`timescale 1ns/100ps

module bubl_main_bus_asserts(
    input clk,
    input tokio,
    input main_mreq_n,
    input main_rom_cs, vram_cs, pal_cs, work_sel, mcram_sel,
    input snd_sel, cab_sel, misc_we, flip_we, sub_nmi
);
    logic [9:0] sels;

    assign sels = {main_rom_cs, vram_cs, pal_cs, work_sel, mcram_sel,
                   snd_sel, cab_sel, misc_we, flip_we, sub_nmi};

    one_select: assert property (@(posedge clk) $onehot0(sels))
        else $error("More than one decoder select active: %b", sels);

    select_needs_mreq: assert property (@(posedge clk) main_mreq_n |-> sels == '0)
        else $error("Decoder select active without a memory request");

    tokio_only: assert property (@(posedge clk) !tokio |-> !cab_sel && !flip_we)
        else $error("Cabinet or flip strobe in Bubble Bobble mode");

endmodule

// ==== tests/bubl_main_bus_tb.sv ====
/*
 * Testbench for the main CPU bus controller
 *   clock, reset and fixed cabinet and source values
 *   bus operations read from tests/bus_tests.txt
 *   per-test report, closing counts and cycle limit
 */

`timescale 1ns/100ps

module bubl_main_bus_tb;
    import bubl_pkg::*;

    // Distinct constant on each read source
    localparam logic [7:0] rom_val   = 8'ha1;
    localparam logic [7:0] vram_val  = 8'hb2;
    localparam logic [7:0] pal_val   = 8'hc3;
    localparam logic [7:0] latch_val = 8'hd4;
    localparam int         max_lines = 64;

    logic        clk24, rst, tokio, main_mreq_n, main_iorq_n, main_rd_n, main_wr_n, main_stb;
    logic [addr_w-1:0] main_addr;
    logic [data_w-1:0] main_dout;

    wire  [data_w-1:0]     main_din, snd_latch, cpu_dout;
    wire  [rom_addr_w-1:0] main_rom_addr;
    wire  [cpu_addr_w-1:0] cpu_addr;
    wire         main_rom_cs, vram_cs, pal_cs, cpu_rnw, black_n, flip, sub_rst_n, mcu_rst;
    wire         sub_nmi, snd_stb, snd_rstn, main_flag;
    wire  [7:0]  ctrl_out;

    int          tid[0:max_lines-1], game[0:max_lines-1], op[0:max_lines-1];
    logic [15:0] addr[0:max_lines-1];
    logic [7:0]  data[0:max_lines-1], exp_din[0:max_lines-1];
    logic [17:0] exp_rom[0:max_lines-1];
    logic [7:0]  exp_ctrl[0:max_lines-1], exp_latch[0:max_lines-1];
    int          n = 0, errors = 0, test_errs = 0, checks = 0, tests = 0;
    int          cycles = 0, limit = 0;

    assign ctrl_out = {1'b0, black_n, flip, sub_rst_n, mcu_rst, snd_rstn, main_flag, snd_stb};

    bubl_main_bus bubl_main_bus_i(
        .clk24(clk24), .rst(rst), .tokio(tokio), .main_addr(main_addr),
        .main_dout(main_dout), .main_mreq_n(main_mreq_n), .main_iorq_n(main_iorq_n),
        .main_rd_n(main_rd_n), .main_wr_n(main_wr_n), .main_din(main_din),
        .main_rom_data(rom_val), .vram_dout(vram_val), .pal_dout(pal_val),
        .main_rom_addr(main_rom_addr), .main_rom_cs(main_rom_cs), .vram_cs(vram_cs),
        .pal_cs(pal_cs), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_rnw(cpu_rnw),
        .black_n(black_n), .flip(flip), .sub_rst_n(sub_rst_n), .mcu_rst(mcu_rst),
        .sub_nmi(sub_nmi), .main_latch(latch_val), .snd_flag(1'b1), .main_stb(main_stb),
        .snd_latch(snd_latch), .snd_stb(snd_stb), .snd_rstn(snd_rstn),
        .main_flag(main_flag), .start_button(2'b10), .coin_input(2'b01),
        .joystick1(6'b101100), .joystick2(6'b010011), .dipsw_a(8'h69), .dipsw_b(8'h3c));

    bind main_addr_dec bubl_main_bus_asserts bubl_main_bus_asserts_i(
        .clk(bubl_main_bus_tb.clk24), .*);

    initial begin
        clk24 = 1'b0;
        forever #4 clk24 = ~clk24;
    end

    // Cycle limit, set once the test lines are loaded
    always @(posedge clk24) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, the bus operations did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////
    // Bus operations, each returns at the check point
    task automatic bus_write(input int g, input logic [15:0] a, input logic [7:0] d);
        @(posedge clk24);
        tokio       <= g[0];
        main_addr   <= a;
        main_dout   <= d;
        main_mreq_n <= 1'b0;
        main_rd_n   <= 1'b1;
        main_wr_n   <= 1'b0;
        @(negedge clk24);
        check_bus_outputs(g, a, 1'b1);   // Strobes only live during the write
        checks++;
        if (cpu_dout !== d)
            report_mismatch("cpu_dout", d, cpu_dout);
        @(posedge clk24);
        main_mreq_n <= 1'b1;
        main_wr_n   <= 1'b1;
        @(negedge clk24);
    endtask

    task automatic bus_read(input int g, input logic [15:0] a);
        @(posedge clk24);
        tokio       <= g[0];
        main_addr   <= a;
        main_mreq_n <= 1'b0;
        main_rd_n   <= 1'b0;
        main_wr_n   <= 1'b1;
        repeat (2) @(posedge clk24);   // Cabinet reads need two edges
        @(negedge clk24);
        check_bus_outputs(g, a, 1'b0);
    endtask

    task automatic pulse_stb;
        @(posedge clk24);
        main_mreq_n <= 1'b1;
        main_rd_n   <= 1'b1;
        main_wr_n   <= 1'b1;
        main_stb    <= 1'b1;
        @(posedge clk24);
        main_stb <= 1'b0;
        @(negedge clk24);
    endtask

    // Chip selects, sub NMI and video side pass-through while the bus is held
    task automatic check_bus_outputs(input int g, input logic [15:0] a, input logic wr);
        logic exp_rom_cs, exp_vram_cs, exp_pal_cs, exp_nmi;

        exp_rom_cs  = a <= 16'hbfff;
        exp_vram_cs = a >= 16'hc000 && a <= 16'hdfff;
        exp_pal_cs  = a >= 16'hf800 && a <= 16'hf9ff;
        if (g[0])
            exp_nmi = wr && a >= 16'hfb80 && a <= 16'hfbff;
        else
            exp_nmi = wr && a >= 16'hfb00 && a <= 16'hfb3f;
        checks += 6;
        if (main_rom_cs !== exp_rom_cs)
            report_mismatch("main_rom_cs", exp_rom_cs, main_rom_cs);
        if (vram_cs !== exp_vram_cs)
            report_mismatch("vram_cs", exp_vram_cs, vram_cs);
        if (pal_cs !== exp_pal_cs)
            report_mismatch("pal_cs", exp_pal_cs, pal_cs);
        if (sub_nmi !== exp_nmi)
            report_mismatch("sub_nmi", exp_nmi, sub_nmi);
        if (cpu_addr !== a[12:0])
            report_mismatch("cpu_addr", a[12:0], cpu_addr);
        if (cpu_rnw !== !wr)
            report_mismatch("cpu_rnw", !wr, cpu_rnw);
    endtask

    task automatic report_mismatch(input string name, input logic [17:0] exp_v,
                                   input logic [17:0] act_v);
        $display("FAIL %0t %s expected %h got %h", $time, name, exp_v, act_v);
        errors++;
        test_errs++;
    endtask

    task automatic finish_test(input int id);
        $display("test %0d %s, %0d errors", id, test_errs == 0 ? "ok" : "wrong", test_errs);
        tests++;
        test_errs = 0;
    endtask

    initial begin
        string line;
        int    fd, got;

        rst = 1'b1;
        tokio = 1'b0;
        main_addr = '0;
        main_dout = '0;
        main_mreq_n = 1'b1;
        main_iorq_n = 1'b1;   // No I/O cycles
        main_rd_n = 1'b1;
        main_wr_n = 1'b1;
        main_stb = 1'b0;
        fd = $fopen("tests/bus_tests.txt", "r");
        if (fd == 0)
            $display("Could not open tests/bus_tests.txt");
        while (fd != 0 && !$feof(fd) && n < max_lines) begin
            got = $fgets(line, fd);
            if (got > 0 && line[0] != "#") begin
                got = $sscanf(line, "%d %d %d %h %h %h %h %h %h", tid[n], game[n], op[n],
                              addr[n], data[n], exp_din[n], exp_rom[n], exp_ctrl[n],
                              exp_latch[n]);
                if (got == 9)
                    n++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        limit = 4 * (n + 2);

        repeat (2) @(posedge clk24);
        rst <= 1'b0;

        for (int i = 0; i < n; i++) begin
            if (i > 0 && tid[i] != tid[i-1])
                finish_test(tid[i-1]);
            case (op[i])
                0:       bus_write(game[i], addr[i], data[i]);
                1:       bus_read(game[i], addr[i]);
                default: pulse_stb;
            endcase
            if (op[i] == 1) begin
                checks += 2;
                if (main_din !== exp_din[i])
                    report_mismatch("main_din", exp_din[i], main_din);
                if (main_rom_addr !== exp_rom[i])
                    report_mismatch("main_rom_addr", exp_rom[i], main_rom_addr);
            end
            checks += 2;
            if (ctrl_out !== exp_ctrl[i])
                report_mismatch("ctrl", exp_ctrl[i], ctrl_out);
            if (snd_latch !== exp_latch[i])
                report_mismatch("snd_latch", exp_latch[i], snd_latch);
        end
        if (n > 0)
            finish_test(tid[n-1]);
        else
            $display("No test lines were read from tests/bus_tests.txt");

        $display("%0d tests, %0d lines, %0d checks, %0d errors", tests, n, checks, errors);
        if (errors == 0 && n > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== tests/bus_tests.txt ====
# id game op addr data din rom_addr ctrl latch  (hex from addr on, din and rom checked on reads)
# game 1 = Tokio, op 0 write 1 read 2 main_stb pulse, ctrl = 0 black_n flip sub_rst_n mcu_rst snd_rstn main_flag snd_stb
1 0 0 FB40 73 00 00000 56 00
1 0 1 9234 00 A1 25234 56 00
1 0 1 5678 00 A1 05678 56 00
2 0 1 C123 00 B2 24123 56 00
2 0 1 F9AB 00 C3 279AB 56 00
2 0 1 FD00 00 FF 27D00 56 00
2 1 1 FE10 00 BF 27E10 56 00
2 1 1 E800 00 FF 26800 56 00
2 1 1 FD00 00 FF 27D00 56 00
3 0 0 FB40 83 00 00000 2E 00
3 1 0 FA80 43 00 00000 7E 00
3 1 0 FB00 00 00 00000 5E 00
4 0 0 FA00 5A 00 00000 5F 5A
4 0 0 FA03 01 00 00000 5A 5A
4 1 1 FC02 00 D4 27C02 58 5A
4 0 1 FA01 00 FD 27A01 58 5A
5 0 2 0000 00 00 00000 5A 5A
5 0 1 FA01 00 FD 27A01 58 5A
5 0 2 0000 00 00 00000 5A 5A
6 1 1 FA00 00 FF 27A00 5A 5A
6 1 1 FA03 00 69 27A03 5A 5A
6 1 1 FA04 00 3C 27A04 5A 5A
6 1 1 FA05 00 F7 27A05 5A 5A
6 1 1 FA06 00 9C 27A06 5A 5A
6 1 1 FA07 00 E3 27A07 5A 5A

// ==== project.f ====
hdl/bubl_pkg.sv
hdl/main_addr_dec.sv
hdl/main_ctrl_reg.sv
hdl/snd_comm.sv
hdl/cab_port.sv
hdl/main_din_mux.sv
hdl/bubl_main_bus.sv
tests/bubl_main_bus_asserts.sv
tests/bubl_main_bus_tb.sv

// ==== Bender.yml ====
package:
  name: bubl_main_bus

sources:
  - hdl/bubl_pkg.sv
  - hdl/main_addr_dec.sv
  - hdl/main_ctrl_reg.sv
  - hdl/snd_comm.sv
  - hdl/cab_port.sv
  - hdl/main_din_mux.sv
  - hdl/bubl_main_bus.sv
  - target: test
    files:
      - tests/bubl_main_bus_asserts.sv
      - tests/bubl_main_bus_tb.sv
